// ==== Makefile ====
TOP  := tb_desc_wrback
SIM  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' sources.f)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) sources.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f

# The run fails unless the testbench printed its pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST OK$$'

clean:
	rm -rf obj_dir

// ==== dv/desc_wrback_chk.sv ====
// ##########################################################################
// Write-back protocol assertions
// ##########################################################################

module desc_wrback_chk
    import desc_wrback_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  st_snk_ready,
    input logic  get_resp_fifo,
    input logic  reset_complete,
    input logic  mm_write_write,
    input logic  mm_write_waitrequest,
    input addr_t mm_write_address,
    input data_t mm_write_writedata,
    input be_t   mm_write_byteenable
);
    timeunit 1ns;
    timeprecision 1ps;

    // A stalled write keeps its request and its whole beat in place
    assert property (@(posedge clk) disable iff (reset)
        (mm_write_write && mm_write_waitrequest) |=>
            (mm_write_write && $stable(mm_write_address) &&
             $stable(mm_write_writedata) && $stable(mm_write_byteenable)))
        else $error("write beat changed while waitrequest was high");

    assert property (@(posedge clk) disable iff (reset)
        st_snk_ready |=> !st_snk_ready)
        else $error("st_snk_ready was high for more than one cycle");

    // The FIFO pop leads the stream ready by exactly one cycle
    assert property (@(posedge clk) disable iff (reset)
        get_resp_fifo |=> st_snk_ready)
        else $error("get_resp_fifo was not followed by st_snk_ready");

    assert property (@(posedge clk) disable iff (reset)
        reset_complete |-> !mm_write_write)
        else $error("write issued while reset_complete was high");

endmodule

// ==== dv/tb_desc_wrback.sv ====
// ##########################################################################
// Descriptor write-back testbench
// ##########################################################################

module tb_desc_wrback
    import desc_wrback_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_WORDS  = 40;
    localparam int WAIT_LIMIT = 200;

    logic       clk;
    logic       reset;
    logic       run;
    logic       reset_prefetcher;
    logic       park_mode;
    logic       st_snk_valid;
    status_t    st_snk_data;
    logic       st_snk_ready;
    resp_t      resp_fifo_rdata;
    logic       get_resp_fifo;
    logic       mm_write_waitrequest = 1'b0;
    logic       mm_write_writeresponsevalid = 1'b0;
    addr_t      mm_write_address;
    data_t      mm_write_writedata;
    be_t        mm_write_byteenable;
    logic       mm_write_write;
    logic       write_back_done;
    logic [7:0] error;
    logic       early_termination;
    logic       transfer_complete_irq_mask;
    logic [7:0] error_irq_mask;
    logic       early_termination_irq_mask;
    logic       reset_complete;

    // Bus and handshake state kept by the slave model
    addr_t wr_addr_q[$];
    data_t wr_data_q[$];
    be_t   wr_be_q[$];
    int    pending;
    int    total_resp;
    int    gets_seen;
    int    readies_seen;
    int    hs_errors;

    int    beat_rd;
    int    checks;
    int    fails[5];
    string names[5] = '{"beat content", "park snapshot", "status fields",
                        "completion handshake", "prefetcher reset"};

    desc_wrback u_dut (
        .clk                         (clk),
        .reset                       (reset),
        .run                         (run),
        .reset_prefetcher            (reset_prefetcher),
        .park_mode                   (park_mode),
        .st_snk_valid                (st_snk_valid),
        .st_snk_data                 (st_snk_data),
        .st_snk_ready                (st_snk_ready),
        .resp_fifo_rdata             (resp_fifo_rdata),
        .get_resp_fifo               (get_resp_fifo),
        .mm_write_waitrequest        (mm_write_waitrequest),
        .mm_write_writeresponsevalid (mm_write_writeresponsevalid),
        .mm_write_address            (mm_write_address),
        .mm_write_writedata          (mm_write_writedata),
        .mm_write_byteenable         (mm_write_byteenable),
        .mm_write_write              (mm_write_write),
        .write_back_done             (write_back_done),
        .error                       (error),
        .early_termination           (early_termination),
        .transfer_complete_irq_mask  (transfer_complete_irq_mask),
        .error_irq_mask              (error_irq_mask),
        .early_termination_irq_mask  (early_termination_irq_mask),
        .reset_complete              (reset_complete)
    );

    bind desc_wrback desc_wrback_chk u_chk (
        .clk                  (clk),
        .reset                (reset),
        .st_snk_ready         (st_snk_ready),
        .get_resp_fifo        (get_resp_fifo),
        .reset_complete       (reset_complete),
        .mm_write_write       (mm_write_write),
        .mm_write_waitrequest (mm_write_waitrequest),
        .mm_write_address     (mm_write_address),
        .mm_write_writedata   (mm_write_writedata),
        .mm_write_byteenable  (mm_write_byteenable)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Memory slave with random waitrequest and in-order responses after random delays
    always @(posedge clk) begin
        if (reset) begin
            pending    = 0;
            total_resp = 0;
        end else begin
            if (mm_write_write && !mm_write_waitrequest) begin
                wr_addr_q.push_back(mm_write_address);
                wr_data_q.push_back(mm_write_writedata);
                wr_be_q.push_back(mm_write_byteenable);
                pending = pending + 1;
            end
            if (mm_write_writeresponsevalid) begin
                pending    = pending - 1;
                total_resp = total_resp + 1;
            end
            if (write_back_done !== st_snk_ready) begin
                $display("[FAIL] %0t ns: write_back_done differs from st_snk_ready", $time);
                hs_errors = hs_errors + 1;
            end
            if (get_resp_fifo) begin
                gets_seen = gets_seen + 1;
                if (total_resp != 3 * gets_seen) begin
                    $display("get_resp_fifo at %0t ns came before all three responses",
                             $time);
                    hs_errors = hs_errors + 1;
                end
            end
            if (st_snk_ready) begin
                readies_seen = readies_seen + 1;
            end
        end
        #1;
        mm_write_waitrequest        = ($urandom % 3) == 0;
        mm_write_writeresponsevalid = !reset && (pending > 0) && (($urandom % 3) == 0);
    end

    task automatic record(input int id, input logic ok);
        checks = checks + 1;
        if (!ok) begin
            fails[id] = fails[id] + 1;
        end
    endtask

    task automatic check_beat(input int id, input int beat, input addr_t ea, input data_t ed,
                              input be_t eb, input addr_t ga, input data_t gd, input be_t gb);
        logic ok;
        ok = (ga === ea) && (gd === ed) && (gb === eb);
        record(id, ok);
        if (!ok) begin
            $display("[FAIL] %0t ns: beat %0d wrote %h/%h/%h, expected %h/%h/%h",
                     $time, beat, ga, gd, gb, ea, ed, eb);
        end
    endtask

    // Field layout of the status word as the dispatcher defines it
    task automatic check_status_fields(input int id, input status_t s);
        logic [18:0] exp_f;
        logic [18:0] got_f;
        exp_f = {s[39:32], s[40], s[41], s[49:42], s[50]};
        got_f = {error, early_termination, transfer_complete_irq_mask,
                 error_irq_mask, early_termination_irq_mask};
        record(id, got_f === exp_f);
        if (got_f !== exp_f) begin
            $display("[FAIL] %0t ns: status fields %h, expected %h", $time, got_f, exp_f);
        end
    endtask

    task automatic check_flag(input int id, input string what, input logic exp_v,
                              input logic got_v);
        record(id, got_v === exp_v);
        if (got_v !== exp_v) begin
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got_v, exp_v);
        end
    endtask

    task automatic random_status(output status_t s);
        for (int i = 0; i < STATUS_WIDTH / 32; i++) begin
            s[i*32 +: 32] = $urandom;
        end
    endtask

    task automatic report_test(input int id);
        $display("%-22s %s (%0d errors)", names[id], (fails[id] == 0) ? "passed" : "failed",
                 fails[id]);
    endtask

    // Drives one status word until it is consumed and checks its three beats
    task automatic run_word(input int n);
        status_t s;
        resp_t   r;
        logic    park;
        logic    wrote;
        logic    done;
        int      cycles;
        addr_t   exp_a[3];
        data_t   exp_d[3];
        be_t     exp_b[3];
        random_status(s);
        r    = {$urandom, $urandom};
        park = ($urandom % 2) == 1;
        st_snk_data     = s;
        resp_fifo_rdata = r;
        park_mode       = park;
        st_snk_valid    = 1'b1;
        wrote  = 1'b0;
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            if (cycles == 0) begin
                check_status_fields(2, s);
            end
            done  = st_snk_ready;
            wrote = wrote | mm_write_write;
            cycles++;
            #1;
            // Snapshot is already taken once the first write is up
            if (wrote) begin
                park_mode = ~park_mode;
            end
        end
        st_snk_valid = 1'b0;
        if (!done) begin
            $display("Word %0d was not consumed within %0d cycles", n, WAIT_LIMIT);
            fails[3] = fails[3] + 1;
        end

        exp_a[0] = r[31:0] + BYTES_OFFSET;
        exp_d[0] = s[31:0];
        exp_b[0] = BYTES_BE;
        exp_a[1] = r[31:0] + STATUS_OFFSET;
        exp_d[1] = '0;
        exp_d[1][8:0] = s[40:32];
        exp_b[1] = STATUS_BE;
        exp_a[2] = r[31:0] + CONTROL_OFFSET;
        exp_d[2] = r[63:32];
        exp_d[2][OWNED_BIT] = park;
        exp_b[2] = CONTROL_BE;

        check_flag(0, "three writes for the word", 1'b1, wr_addr_q.size() == beat_rd + 3);
        if (wr_addr_q.size() >= beat_rd + 3) begin
            for (int b = 0; b < 3; b++) begin
                check_beat(0, b + 1, exp_a[b], exp_d[b], exp_b[b], wr_addr_q[beat_rd + b],
                           wr_data_q[beat_rd + b], wr_be_q[beat_rd + b]);
            end
            check_flag(1, "owned bit", park, wr_data_q[beat_rd + 2][OWNED_BIT]);
        end
        beat_rd = wr_addr_q.size();
        check_flag(3, "one get_resp_fifo per word", 1'b1, gets_seen == n + 1);
        check_flag(3, "one st_snk_ready per word", 1'b1, readies_seen == n + 1);
    endtask

    initial begin
        status_t s;
        logic    seen;
        int      cycles;
        int      total;
        int      passed;
        void'($urandom(32'h76712047));
        reset            = 1'b1;
        run              = 1'b0;
        reset_prefetcher = 1'b0;
        park_mode        = 1'b0;
        st_snk_valid     = 1'b0;
        st_snk_data      = '0;
        resp_fifo_rdata  = '0;
        beat_rd          = 0;
        checks           = 0;
        gets_seen        = 0;
        readies_seen     = 0;
        hs_errors        = 0;
        fails            = '{default: 0};
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // With run low the engine stays idle even with a word offered
        random_status(s);
        st_snk_data  = s;
        st_snk_valid = 1'b1;
        repeat (20) begin
            @(posedge clk);
            check_flag(3, "mm_write_write with run low", 1'b0, mm_write_write);
            check_flag(3, "st_snk_ready with run low", 1'b0, st_snk_ready);
            #1;
        end
        st_snk_valid = 1'b0;
        run          = 1'b1;

        for (int n = 0; n < NUM_WORDS; n++) begin
            repeat ($urandom % 3) @(posedge clk);
            #1;
            run_word(n);
        end
        report_test(0);
        report_test(1);
        report_test(2);

        // Reset request while the engine waits and a word is already offered
        random_status(s);
        st_snk_data      = s;
        st_snk_valid     = 1'b1;
        reset_prefetcher = 1'b1;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < 10) begin
            @(posedge clk);
            seen = reset_complete;
            cycles++;
            #1;
        end
        if (!seen) begin
            $display("reset_complete did not rise within 10 cycles of the request");
            fails[4] = fails[4] + 1;
        end
        repeat (20) begin
            @(posedge clk);
            check_flag(4, "reset_complete during request", 1'b1, reset_complete);
            check_flag(4, "mm_write_write during request", 1'b0, mm_write_write);
            check_flag(4, "st_snk_ready during request", 1'b0, st_snk_ready);
            #1;
        end
        reset_prefetcher = 1'b0;
        st_snk_valid     = 1'b0;
        cycles = 0;
        while (seen && cycles < 10) begin
            @(posedge clk);
            seen = reset_complete;
            cycles++;
            #1;
        end
        if (seen) begin
            $display("reset_complete stayed high after the request was withdrawn");
            fails[4] = fails[4] + 1;
        end
        check_flag(4, "no write during reset request", 1'b1, wr_addr_q.size() == beat_rd);

        check_flag(3, "handshake monitor clean", 1'b1, hs_errors == 0);
        report_test(3);
        report_test(4);

        total  = 0;
        passed = 0;
        for (int i = 0; i < 5; i++) begin
            total = total + fails[i];
            if (fails[i] == 0) begin
                passed++;
            end
        end
        $display("5 tests, %0d passed, %0d checks, %0d errors", passed, checks, total);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/desc_wrback.sv ====
// ##########################################################################
// Descriptor write-back engine
// ##########################################################################

module desc_wrback
    import desc_wrback_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       run,
    input  logic       reset_prefetcher,
    input  logic       park_mode,

    // Status stream from the dispatcher
    input  logic       st_snk_valid,
    input  status_t    st_snk_data,
    output logic       st_snk_ready,

    // Response FIFO read side
    input  resp_t      resp_fifo_rdata,
    output logic       get_resp_fifo,

    // Avalon-MM write master
    input  logic       mm_write_waitrequest,
    input  logic       mm_write_writeresponsevalid,
    output addr_t      mm_write_address,
    output data_t      mm_write_writedata,
    output be_t        mm_write_byteenable,
    output logic       mm_write_write,

    // Interrupt logic and CSR side
    output logic       write_back_done,
    output logic [7:0] error,
    output logic       early_termination,
    output logic       transfer_complete_irq_mask,
    output logic [7:0] error_irq_mask,
    output logic       early_termination_irq_mask,
    output logic       reset_complete
);

    logic start_beats;
    logic writes_accepted;
    logic responses_done;

    desc_wrback_ctrl u_ctrl (
        .clk              (clk),
        .reset            (reset),
        .run              (run),
        .reset_prefetcher (reset_prefetcher),
        .st_snk_valid     (st_snk_valid),
        .writes_accepted  (writes_accepted),
        .responses_done   (responses_done),
        .start_beats      (start_beats),
        .get_resp_fifo    (get_resp_fifo),
        .st_snk_ready     (st_snk_ready),
        .reset_complete   (reset_complete)
    );

    desc_wrback_beat_gen u_beats (
        .clk                         (clk),
        .reset                       (reset),
        .start_beats                 (start_beats),
        .park_mode                   (park_mode),
        .mm_write_waitrequest        (mm_write_waitrequest),
        .mm_write_writeresponsevalid (mm_write_writeresponsevalid),
        .st_snk_data                 (st_snk_data),
        .resp_fifo_rdata             (resp_fifo_rdata),
        .mm_write_address            (mm_write_address),
        .mm_write_writedata          (mm_write_writedata),
        .mm_write_byteenable         (mm_write_byteenable),
        .mm_write_write              (mm_write_write),
        .writes_accepted             (writes_accepted),
        .responses_done              (responses_done)
    );

    // The write-back is done when the status word is consumed
    assign write_back_done = st_snk_ready;

    assign error                      = st_snk_data[ERR_MSB:ERR_LSB];
    assign early_termination          = st_snk_data[EARLY_TERM_BIT];
    assign transfer_complete_irq_mask = st_snk_data[XFER_IRQ_BIT];
    assign error_irq_mask             = st_snk_data[ERR_IRQ_MSB:ERR_IRQ_LSB];
    assign early_termination_irq_mask = st_snk_data[EARLY_IRQ_BIT];

endmodule

// ==== logic/desc_wrback_beat_gen.sv ====
// ##########################################################################
// Write-back beat generator
// ##########################################################################

module desc_wrback_beat_gen
    import desc_wrback_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    start_beats,
    input  logic    park_mode,
    input  logic    mm_write_waitrequest,
    input  logic    mm_write_writeresponsevalid,
    input  status_t st_snk_data,
    input  resp_t   resp_fifo_rdata,
    output addr_t   mm_write_address,
    output data_t   mm_write_writedata,
    output be_t     mm_write_byteenable,
    output logic    mm_write_write,
    output logic    writes_accepted,
    output logic    responses_done
);

    // The counters run down, so the first beat has the highest count
    localparam beat_cnt_t BEAT_BYTES   = beat_cnt_t'(NUM_BEATS - 1);
    localparam beat_cnt_t BEAT_STATUS  = beat_cnt_t'(1);
    localparam beat_cnt_t BEAT_CONTROL = beat_cnt_t'(0);

    beat_cnt_t req_cnt;
    beat_cnt_t req_cnt_nxt;
    beat_cnt_t resp_cnt;
    beat_cnt_t resp_cnt_nxt;
    logic      owned_snap;
    logic      write_accept;
    logic      load_beat;
    addr_t     desc_ptr;
    data_t     ctrl_word;
    addr_t     beat_addr;
    data_t     beat_data;
    be_t       beat_be;

    assign write_accept    = mm_write_write && !mm_write_waitrequest;
    assign writes_accepted = write_accept && (req_cnt == BEAT_CONTROL);
    assign responses_done  = mm_write_writeresponsevalid && (resp_cnt == BEAT_CONTROL);

    always_comb begin
        if (start_beats) begin
            req_cnt_nxt = BEAT_BYTES;
        end else if (write_accept && (req_cnt != BEAT_CONTROL)) begin
            req_cnt_nxt = req_cnt - 1'b1;
        end else begin
            req_cnt_nxt = req_cnt;
        end
    end

    // Responses come back in order, one per accepted write
    always_comb begin
        if (start_beats) begin
            resp_cnt_nxt = BEAT_BYTES;
        end else if (mm_write_writeresponsevalid && (resp_cnt != BEAT_CONTROL)) begin
            resp_cnt_nxt = resp_cnt - 1'b1;
        end else begin
            resp_cnt_nxt = resp_cnt;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_cnt  <= BEAT_CONTROL;
            resp_cnt <= BEAT_CONTROL;
        end else begin
            req_cnt  <= req_cnt_nxt;
            resp_cnt <= resp_cnt_nxt;
        end
    end

    // Park mode is sampled once per write-back so a CSR change during the
    // beats cannot give the descriptor a mixed ownership value
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            owned_snap <= 1'b0;
        end else if (start_beats) begin
            owned_snap <= park_mode;
        end
    end

    assign desc_ptr = resp_fifo_rdata[ADDR_WIDTH-1:0];

    always_comb begin
        ctrl_word            = resp_fifo_rdata[RESP_WIDTH-1 -: DATA_WIDTH];
        ctrl_word[OWNED_BIT] = owned_snap;
    end

    always_comb begin
        beat_addr = '0;
        beat_data = '0;
        beat_be   = '0;
        case (req_cnt_nxt)
            BEAT_BYTES: begin
                beat_addr = desc_ptr + BYTES_OFFSET;
                beat_data = st_snk_data[DATA_WIDTH-1:0];
                beat_be   = BYTES_BE;
            end
            BEAT_STATUS: begin
                beat_addr = desc_ptr + STATUS_OFFSET;
                beat_data = data_t'(st_snk_data[EARLY_TERM_BIT:ERR_LSB]);
                beat_be   = STATUS_BE;
            end
            BEAT_CONTROL: begin
                beat_addr = desc_ptr + CONTROL_OFFSET;
                beat_data = ctrl_word;
                beat_be   = CONTROL_BE;
            end
            default: begin
                beat_be = '0;
            end
        endcase
    end

    // New content on start and after every accepted write but the last
    assign load_beat = start_beats || (write_accept && (req_cnt != BEAT_CONTROL));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mm_write_address    <= '0;
            mm_write_writedata  <= '0;
            mm_write_byteenable <= '0;
        end else if (load_beat) begin
            mm_write_address    <= beat_addr;
            mm_write_writedata  <= beat_data;
            mm_write_byteenable <= beat_be;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mm_write_write <= 1'b0;
        end else if (mm_write_write) begin
            mm_write_write <= !writes_accepted;
        end else begin
            mm_write_write <= start_beats;
        end
    end

endmodule

// ==== logic/desc_wrback_ctrl.sv ====
// ##########################################################################
// Descriptor write-back FSM
// ##########################################################################

module desc_wrback_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic run,
    input  logic reset_prefetcher,
    input  logic st_snk_valid,
    input  logic writes_accepted,
    input  logic responses_done,
    output logic start_beats,
    output logic get_resp_fifo,
    output logic st_snk_ready,
    output logic reset_complete
);

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_WAIT_ST  = 3'd1;
    localparam logic [2:0] S_WR_REQ   = 3'd2;
    localparam logic [2:0] S_WR_WAIT  = 3'd3;
    localparam logic [2:0] S_WR_PEND  = 3'd4;
    localparam logic [2:0] S_WR_DONE  = 3'd5;
    localparam logic [2:0] S_ST_READY = 3'd6;

    logic [2:0] state;
    logic [2:0] state_nxt;
    logic       idle_state;
    logic       wait_st_state;
    logic       wr_done_state;
    logic       st_ready_state;
    logic       reset_complete_nxt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (run && !reset_prefetcher) begin
                    state_nxt = S_WAIT_ST;
                end
            end
            S_WAIT_ST: begin
                // A reset request can arrive while the dispatcher has nothing
                // left to report, so it must not be stuck waiting here
                if (reset_prefetcher) begin
                    state_nxt = S_IDLE;
                end else if (st_snk_valid) begin
                    state_nxt = S_WR_REQ;
                end
            end
            S_WR_REQ: begin
                state_nxt = S_WR_WAIT;
            end
            S_WR_WAIT: begin
                if (writes_accepted) begin
                    state_nxt = S_WR_PEND;
                end
            end
            S_WR_PEND: begin
                if (responses_done) begin
                    state_nxt = S_WR_DONE;
                end
            end
            S_WR_DONE: begin
                state_nxt = S_ST_READY;
            end
            S_ST_READY: begin
                if (reset_prefetcher) begin
                    state_nxt = S_IDLE;
                end else begin
                    state_nxt = S_WAIT_ST;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    assign idle_state     = (state == S_IDLE);
    assign wait_st_state  = (state == S_WAIT_ST);
    assign wr_done_state  = (state == S_WR_DONE);
    assign st_ready_state = (state == S_ST_READY);

    assign start_beats = (state == S_WR_REQ);

    // The response FIFO has a read latency of 2, so it is popped one cycle
    // ahead of the stream ready to have the next entry settled in time
    // for a back-to-back write-back
    assign get_resp_fifo = wr_done_state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            st_snk_ready <= 1'b0;
        end else begin
            st_snk_ready <= wr_done_state;
        end
    end

    // Reset completes only outside a write-back and then holds until
    // the request is withdrawn
    assign reset_complete_nxt = reset_complete ? reset_prefetcher :
        (reset_prefetcher && (idle_state || wait_st_state || st_ready_state));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reset_complete <= 1'b0;
        end else begin
            reset_complete <= reset_complete_nxt;
        end
    end

endmodule

// ==== logic/desc_wrback_pkg.sv ====
// ##########################################################################
// Descriptor write-back format
// ##########################################################################

package desc_wrback_pkg;

    // Avalon-MM write master widths for the standard descriptor layout
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH   = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [BE_WIDTH-1:0]   be_t;

    // Status word from the dispatcher
    localparam int STATUS_WIDTH = 256;
    typedef logic [STATUS_WIDTH-1:0] status_t;

    // Response FIFO word with the descriptor pointer low and the control word high
    localparam int RESP_WIDTH = 64;
    typedef logic [RESP_WIDTH-1:0] resp_t;

    // Field positions inside the status word
    localparam int ERR_LSB        = 32;
    localparam int ERR_MSB        = 39;
    localparam int EARLY_TERM_BIT = 40;
    localparam int XFER_IRQ_BIT   = 41;
    localparam int ERR_IRQ_LSB    = 42;
    localparam int ERR_IRQ_MSB    = 49;
    localparam int EARLY_IRQ_BIT  = 50;

    // Descriptor offsets of the three fields written back
    localparam addr_t BYTES_OFFSET   = 32'd16;
    localparam addr_t STATUS_OFFSET  = 32'd20;
    localparam addr_t CONTROL_OFFSET = 32'd28;

    // Status is a 16-bit field, so only the low two lanes are written
    localparam be_t BYTES_BE   = 4'hf;
    localparam be_t STATUS_BE  = 4'h3;
    localparam be_t CONTROL_BE = 4'hf;

    // Hardware ownership bit of the control word
    localparam int OWNED_BIT = 30;

    localparam int NUM_BEATS = 3;
    typedef logic [$clog2(NUM_BEATS)-1:0] beat_cnt_t;

endpackage

// ==== sources.f ====
logic/desc_wrback_pkg.sv
logic/desc_wrback_ctrl.sv
logic/desc_wrback_beat_gen.sv
logic/desc_wrback.sv
dv/desc_wrback_chk.sv
dv/tb_desc_wrback.sv
